// ==== dv/ctc_tb_tasks.svh ====
////////////////////////////////////////////////////////////
// sequencing helpers, all entered and left at edge + 2 ns
////////////////////////////////////////////////////////////

task automatic abort_timeout(input string what);
    $display("timeout while waiting for %s", what);
    $display("ERRORS FOUND");
    $finish;
endtask

task automatic step(input int n);
    repeat (n) begin
        @(posedge clock);
        #2;                                     // drive phase
    end
endtask

// hold req until the accepting edge, return just after it
task automatic send_req(input logic is_wr, input logic [2:0] addr, input logic [15:0] data);
    int n;
    n = 0;
    req_valid = 1'b1;
    req.write = is_wr;
    req.addr  = addr;
    req.wdata = data;
    while (!req_ready && n < wait_limit) begin
        step(1);
        n++;
    end
    if (!req_ready) abort_timeout("req_ready");
    step(1);                                    // accepting edge
    req_valid = 1'b0;
endtask

task automatic bus_write(input logic [2:0] addr, input logic [15:0] data);
    send_req(1'b1, addr, data);
    if (addr == off_mode0) mode_m[0] = data;    // model follows mode writes
    if (addr == off_mode1) mode_m[1] = data;
endtask

task automatic bus_read(input logic [2:0] addr, output logic [15:0] data);
    int n;
    n = 0;
    send_req(1'b0, addr, '0);
    while (!rsp_valid && n < wait_limit) begin
        step(1);
        n++;
    end
    if (!rsp_valid) abort_timeout("rsp_valid");
    data = rsp.rdata;
    step(1);                                    // rsp_ready high, drains here
endtask

// step first, so a pulse seen last call is not counted twice
task automatic wait_low(input int ch, input int limit);
    int n;
    n = 0;
    do begin
        step(1);
        n++;
    end while (cout_n[ch] !== 1'b0 && n < limit);
    if (cout_n[ch] !== 1'b0) abort_timeout($sformatf("a low pulse on cout_n[%0d]", ch));
endtask

task automatic check_val(input string name, input logic [15:0] got, input logic [15:0] exp);
    assert (got === exp) else begin
        $display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
        err_cnt++;
    end
endtask

task automatic start_test(input string name);
    test_name = name;
    test_err0 = err_cnt;                        // errors before this test
    test_cnt++;
endtask

task automatic finish_test();
    if (err_cnt == test_err0) pass_cnt++;
    $display("%-24s %s", test_name, (err_cnt == test_err0) ? "pass" : "FAIL");
endtask

// ==== dv/ctc_tb.sv ====
`timescale 1ns/1ns

module ctc_tb;

    import ctc_bus_pkg::*;
    import ctc_timer_pkg::*;

    localparam int wait_limit = 64;             // cycles per handshake wait

    logic        clock;
    logic        arst_n;
    logic        req_valid;
    logic        req_ready;
    ctc_req_t    req;
    logic        rsp_valid;
    logic        rsp_ready;
    ctc_rsp_t    rsp;
    logic [1:0]  ev_in;
    logic [1:0]  cout_n;
    logic [15:0] mode_m [num_chan];             // mode as last written
    int          cycle_cnt = 0;                 // edges since start
    int          err_cnt   = 0;
    int          pass_cnt  = 0;
    int          test_cnt  = 0;
    int          test_err0 = 0;
    string       test_name;

    `include "ctc_tb_tasks.svh"

    // status word rebuilt from the bit map, not from the DUT
    function automatic logic [15:0] status_word(input logic act, input logic dn, input logic to);
        return {act, 13'd0, dn, to};
    endfunction

    ctc_top u_dut (
        .clock (clock), .arst_n (arst_n),
        .req_valid (req_valid), .req_ready (req_ready), .req (req),
        .rsp_valid (rsp_valid), .rsp_ready (rsp_ready), .rsp (rsp),
        .ev_in (ev_in), .cout_n (cout_n)
    );

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;             // 20 ns period
    end

    always @(posedge clock) cycle_cnt <= cycle_cnt + 1;

    ////////////////////////////////////////////////////////////
    // protocol and pin checks
    ////////////////////////////////////////////////////////////

    assert property (@(posedge clock) disable iff (!arst_n)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp))
        else begin
            $display("response dropped or changed while rsp_ready was low");
            err_cnt++;
        end

    assert property (@(posedge clock) disable iff (!arst_n) rsp_valid |-> !req_ready)
        else begin
            $display("req_ready was high while a response was pending");
            err_cnt++;
        end

    for (genvar i = 0; i < 2; i++) begin : g_pin
        assert property (@(posedge clock) disable iff (!arst_n) $fell(cout_n[i]) |=> cout_n[i])
            else begin
                $display("cout_n[%0d] stayed low for more than one cycle", i);
                err_cnt++;
            end
        assert property (@(posedge clock) disable iff (!arst_n) !cout_n[i] |-> !mode_m[i][0])
            else begin
                $display("cout_n[%0d] went low in counter mode", i);
                err_cnt++;
            end
    end

    ////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////

    initial begin
        int          n_init;
        int          sent;
        int          t0;
        int          t_stop;
        int          hold;
        logic [15:0] rd;
        logic [15:0] held;
        logic [15:0] frozen;
        logic [15:0] c1_before;
        void'($urandom(80822));                 // one seed for the run
        arst_n    = 1'b0;
        req_valid = 1'b0;
        req       = '0;
        rsp_ready = 1'b1;
        ev_in     = '0;
        mode_m[0] = '0;
        mode_m[1] = '0;
        repeat (8) @(posedge clock);
        #2 arst_n = 1'b1;
        step(2);

        start_test("reset values");
        bus_read(off_mode0, rd); check_val("status0", rd, 16'h0000);
        bus_read(off_mode1, rd); check_val("status1", rd, 16'h0000);
        bus_read(off_init0, rd); check_val("count0", rd, 16'h0000);
        bus_read(off_init1, rd); check_val("count1", rd, 16'h0000);
        check_val("cout_n", {14'd0, cout_n}, 16'h0003);
        finish_test();

        start_test("timer one-shot ch0");
        n_init = 2 + $urandom % 39;             // 2..40
        bus_write(off_mode0, 16'h0000);
        bus_write(off_init0, 16'(n_init));
        t0 = cycle_cnt;                         // accepting edge
        wait_low(0, n_init + 8);
        check_val("cout_n[0] delay", 16'(cycle_cnt - t0), 16'(n_init));
        bus_read(off_mode0, rd); check_val("status0", rd, status_word(0, 0, 1));
        bus_read(off_init0, rd); check_val("count0", rd, 16'h0000);
        bus_read(off_mode0, rd); check_val("status0", rd, 16'h0000);
        finish_test();

        start_test("timer repeat ch1");
        n_init = 4 + $urandom % 17;             // 4..20
        bus_write(off_mode1, 16'h0002);         // repeat, timer
        bus_write(off_init1, 16'(n_init));
        t0 = cycle_cnt;
        for (int k = 0; k < 3; k++) begin
            wait_low(1, n_init + 8);
            check_val("cout_n[1] period", 16'(cycle_cnt - t0), 16'(n_init));
            t0 = cycle_cnt;
        end
        bus_read(off_init1, rd);
        assert (rd >= 16'd1 && rd <= 16'(n_init)) else begin
            $display("Mismatch count1: got 0x%h, expected 0x0001 to 0x%h", rd, 16'(n_init));
            err_cnt++;
        end
        bus_read(off_mode1, rd); check_val("status1", rd, status_word(1, 0, 1));
        bus_write(off_mode1, 16'h0000);         // halt before the next test
        bus_read(off_mode1, rd); check_val("status1.active", {15'd0, rd[15]}, 16'h0000);
        finish_test();

        start_test("counter mode ch0");
        n_init = 3 + $urandom % 6;              // 3..8 events
        bus_write(off_mode0, 16'h0001);
        bus_write(off_init0, 16'(n_init));
        for (sent = 0; sent < n_init / 2; sent++) event_pulse(0);
        step(4);                                // sync latency
        bus_read(off_init0, rd); check_val("count0", rd, 16'(n_init - sent));
        for (; sent < n_init; sent++) event_pulse(0);
        step(4);
        bus_read(off_mode0, rd); check_val("status0", rd, status_word(0, 1, 0));
        bus_read(off_init0, rd); check_val("count0", rd, 16'h0000);
        finish_test();

        start_test("stop by mode write");
        bus_write(off_mode0, 16'h0000);
        bus_write(off_init0, 16'd60);
        t0 = cycle_cnt;
        step(10);
        bus_write(off_mode0, 16'h0000);         // stop edge holds the count
        t_stop = cycle_cnt;
        bus_read(off_init0, frozen);
        check_val("count0", frozen, 16'(60 - (t_stop - 1 - t0)));
        step(8);
        bus_read(off_init0, rd); check_val("count0", rd, frozen);
        bus_read(off_mode0, rd); check_val("status0", rd, 16'h0000);
        for (int k = 0; k < 80; k++) begin
            step(1);
            check_val("cout_n[0]", {15'd0, cout_n[0]}, 16'h0001);
        end
        finish_test();

        start_test("bus behavior");
        rsp_ready = 1'b0;                       // back-pressure the response
        send_req(1'b0, off_init0, '0);
        held = rsp.rdata;
        hold = 3 + $urandom % 8;
        for (int k = 0; k < hold; k++) begin
            step(1);
            check_val("rsp_valid", {15'd0, rsp_valid}, 16'h0001);
            check_val("rsp.rdata", rsp.rdata, held);
            check_val("req_ready", {15'd0, req_ready}, 16'h0000);
        end
        check_val("rsp.rdata", held, frozen);
        rsp_ready = 1'b1;
        step(1);
        check_val("rsp_valid", {15'd0, rsp_valid}, 16'h0000);
        for (int a = 1; a < 8; a += 2) begin
            bus_read(3'(a), rd);
            check_val($sformatf("rdata at offset %0d", a), rd, 16'h0000);
        end
        bus_read(off_init1, c1_before);
        for (int a = 1; a < 8; a += 2) bus_write(3'(a), 16'hffff);
        step(5);
        bus_read(off_init0, rd); check_val("count0", rd, frozen);
        bus_read(off_init1, rd); check_val("count1", rd, c1_before);
        bus_read(off_mode0, rd); check_val("status0", rd, 16'h0000);
        bus_read(off_mode1, rd); check_val("status1", rd, 16'h0000);
        finish_test();

        $display("tests passed %0d of %0d, errors %0d", pass_cnt, test_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    // one event pulse, high and low each 2..5 cycles
    task automatic event_pulse(input int ch);
        int hi;
        int lo;
        hi = 2 + $urandom % 4;
        lo = 2 + $urandom % 4;
        ev_in[ch] = 1'b1;
        step(hi);
        ev_in[ch] = 1'b0;
        step(lo);
    endtask

endmodule

// ==== hdl/ctc_bus_pkg.sv ====
package ctc_bus_pkg;

    ////////////////////////////////////////////////////////////
    // register bus geometry
    ////////////////////////////////////////////////////////////

    localparam int data_w = 16;                 // one register word
    localparam int addr_w = 3;                  // word offset only

    // even offsets hold the registers, odd ones are holes
    localparam logic [addr_w-1:0] off_mode0 = 3'd0; // mode wr / status rd, ch0
    localparam logic [addr_w-1:0] off_mode1 = 3'd2; // mode wr / status rd, ch1
    localparam logic [addr_w-1:0] off_init0 = 3'd4; // init wr / count rd, ch0
    localparam logic [addr_w-1:0] off_init1 = 3'd6; // init wr / count rd, ch1

    ////////////////////////////////////////////////////////////
    // request / response payloads
    ////////////////////////////////////////////////////////////

    // request side, held stable by the master until accepted
    typedef struct packed {
        logic              write;               // 1 write, 0 read
        logic [addr_w-1:0] addr;                // word offset
        logic [data_w-1:0] wdata;               // don't care on reads
    } ctc_req_t;

    // response side, only reads answer
    typedef struct packed {
        logic [data_w-1:0] rdata;               // read data
    } ctc_rsp_t;

endpackage

// ==== hdl/ctc_channel.sv ====
`timescale 1ns/1ns

module ctc_channel (
    input  logic                           clock,
    input  logic                           arst_n,
    input  ctc_timer_pkg::ctc_chan_cfg_t   cfg,    // mode + init from regs
    input  logic                           load,   // init written this edge
    input  logic                           stop,   // mode written this edge
    input  logic                           tick,   // synced event edge
    output logic [ctc_timer_pkg::cnt_w-1:0] count, // current value
    output ctc_timer_pkg::ctc_chan_evt_t   evt,    // report to status
    output logic                           cout_n  // active-low expiry pulse
);

    import ctc_timer_pkg::*;

    logic [cnt_w-1:0] count_q;                  // down-counter
    logic             active_q;                 // counting enabled
    logic             cout_n_q;                 // registered pin
    logic             dec_en;                   // decrement this edge
    logic             at_one;                   // next decrement expires
    logic             expire;                   // 1 -> 0 on this edge
    logic             timer_exp;                // expiry in timer mode
    logic             count_exp;                // expiry in counter mode
    logic             reload;                   // repeat on expiry

    ////////////////////////////////////////////////////////////
    // decrement enable and expiry
    ////////////////////////////////////////////////////////////

    // timer runs on every clock, counter only on ticks
    assign dec_en = cfg.mode.counter_mode ? tick : 1'b1;

    assign at_one = (count_q == cnt_w'(1));     // last step

    // load and stop both override the countdown
    assign expire    = active_q & dec_en & at_one & ~load & ~stop;
    assign timer_exp = expire & ~cfg.mode.counter_mode; // timeout
    assign count_exp = expire & cfg.mode.counter_mode;  // done
    assign reload    = cfg.mode.repeat_en;             // else one-shot

    ////////////////////////////////////////////////////////////
    // counter and active state
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            count_q  <= '0;
            active_q <= 1'b0;
        end else if (load) begin
            count_q  <= cfg.init;               // init arrives bypassed from regs
            active_q <= |cfg.init;              // zero init stays idle
        end else if (stop) begin
            active_q <= 1'b0;                   // freeze count where it is
        end else if (active_q && dec_en) begin
            if (at_one) begin
                if (reload) begin
                    count_q  <= cfg.init;       // start next period
                    active_q <= |cfg.init;
                end else begin
                    count_q  <= '0;             // one-shot ends at zero
                    active_q <= 1'b0;
                end
            end else begin
                count_q <= count_q - cnt_w'(1); // plain step
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // output pin
    ////////////////////////////////////////////////////////////

    // low for the cycle after the 1 -> 0 edge, timer mode only
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            cout_n_q <= 1'b1;                   // idle high
        end else begin
            cout_n_q <= ~timer_exp;             // counter mode never pulses
        end
    end

    assign cout_n = cout_n_q;
    assign count  = count_q;

    // set pulses are combinational so the flag lands on the expiry edge
    always_comb begin
        evt.active      = active_q;             // live level for status[15]
        evt.timeout_set = timer_exp;
        evt.done_set    = count_exp;
    end

endmodule

// ==== hdl/ctc_event_sync.sv ====
`timescale 1ns/1ns

module ctc_event_sync (
    input  logic clock,
    input  logic arst_n,
    input  logic ev_in,                         // async event pin
    output logic tick                           // 1 cycle per rising edge
);

    import ctc_timer_pkg::*;

    ////////////////////////////////////////////////////////////
    // synchronizer chain
    ////////////////////////////////////////////////////////////

    logic [sync_stages-1:0] sync_q;             // [0] may go metastable
    logic                   prev_q;             // last synced level
    logic                   ev_s;               // clean synced level

    assign ev_s = sync_q[sync_stages-1];        // chain output

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            sync_q <= '0;                       // pin assumed low
        end else begin
            sync_q <= {sync_q[sync_stages-2:0], ev_in}; // shift in
        end
    end

    ////////////////////////////////////////////////////////////
    // rising edge detect
    ////////////////////////////////////////////////////////////

    // one extra copy, so a long high level still counts once
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            prev_q <= 1'b0;
        end else begin
            prev_q <= ev_s;                     // delayed copy
        end
    end

    // low to high on the synced side only
    assign tick = ev_s & ~prev_q;               // ev_in rise -> tick in 2..3 cycles

endmodule

// ==== hdl/ctc_regs.sv ====
`timescale 1ns/1ns

module ctc_regs (
    input  logic                            clock,
    input  logic                            arst_n,
    input  logic                            req_valid,
    output logic                            req_ready,
    input  ctc_bus_pkg::ctc_req_t           req,
    output logic                            rsp_valid,
    input  logic                            rsp_ready,
    output ctc_bus_pkg::ctc_rsp_t           rsp,
    output ctc_timer_pkg::ctc_chan_cfg_t    cfg   [ctc_timer_pkg::num_chan],
    output logic [ctc_timer_pkg::num_chan-1:0] load,   // init write strobe
    output logic [ctc_timer_pkg::num_chan-1:0] stop,   // mode write strobe
    input  logic [ctc_timer_pkg::cnt_w-1:0] count [ctc_timer_pkg::num_chan],
    input  ctc_timer_pkg::ctc_chan_evt_t    evt   [ctc_timer_pkg::num_chan]
);

    import ctc_bus_pkg::*;
    import ctc_timer_pkg::*;

    logic                accept;                // handshake this edge
    logic                wr;                    // accepted write
    logic                rd;                    // accepted read
    logic [num_chan-1:0] sel_mode;              // mode/status offset hit
    logic [num_chan-1:0] sel_init;              // init/count offset hit
    logic [num_chan-1:0] stat_clr;              // status read, clear flags
    logic [data_w-1:0]   rd_data;               // read mux out
    ctc_status_t         status_w [num_chan];   // assembled status words
    ctc_mode_t           mode_q   [num_chan];   // mode registers
    logic [cnt_w-1:0]    init_q   [num_chan];   // init registers
    logic [num_chan-1:0] timeout_q;             // sticky timeout
    logic [num_chan-1:0] done_q;                // sticky done
    logic                rsp_valid_q;           // response pending
    ctc_rsp_t            rsp_q;                 // held read data

    ////////////////////////////////////////////////////////////
    // handshake and decode
    ////////////////////////////////////////////////////////////

    assign req_ready = ~rsp_valid_q;            // one read in flight max
    assign accept    = req_valid & req_ready;
    assign wr        = accept & req.write;
    assign rd        = accept & ~req.write;

    // status words, flags plus live active bit
    always_comb begin
        for (int i = 0; i < num_chan; i++) begin
            status_w[i]         = '0;           // unused bits read zero
            status_w[i].active  = evt[i].active;
            status_w[i].done    = done_q[i];
            status_w[i].timeout = timeout_q[i];
        end
    end

    // offset decode and read mux in one place
    always_comb begin
        sel_mode = '0;
        sel_init = '0;
        rd_data  = '0;                          // odd offsets read 0
        case (req.addr)
            off_mode0: begin
                sel_mode[0] = 1'b1;
                rd_data     = status_w[0];
            end
            off_mode1: begin
                sel_mode[1] = 1'b1;
                rd_data     = status_w[1];
            end
            off_init0: begin
                sel_init[0] = 1'b1;
                rd_data     = count[0];
            end
            off_init1: begin
                sel_init[1] = 1'b1;
                rd_data     = count[1];
            end
            default: ;                          // holes, no hit
        endcase
    end

    assign load     = sel_init & {num_chan{wr}};  // restart countdown
    assign stop     = sel_mode & {num_chan{wr}};  // mode write halts channel
    assign stat_clr = sel_mode & {num_chan{rd}};  // read-to-clear

    ////////////////////////////////////////////////////////////
    // mode / init registers and sticky flags
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < num_chan; i++) begin
                mode_q[i] <= '0;
                init_q[i] <= '0;
            end
            timeout_q <= '0;
            done_q    <= '0;
        end else begin
            for (int i = 0; i < num_chan; i++) begin
                if (stop[i]) mode_q[i] <= ctc_mode_t'(req.wdata); // kept as written
                if (load[i]) init_q[i] <= req.wdata;
                // set beats clear on the same edge
                if (evt[i].timeout_set)   timeout_q[i] <= 1'b1;
                else if (stat_clr[i])     timeout_q[i] <= 1'b0;
                if (evt[i].done_set)      done_q[i]    <= 1'b1;
                else if (stat_clr[i])     done_q[i]    <= 1'b0;
            end
        end
    end

    // channel sees the new init on the writing edge itself
    always_comb begin
        for (int i = 0; i < num_chan; i++) begin
            cfg[i].mode = mode_q[i];
            cfg[i].init = load[i] ? req.wdata : init_q[i];
        end
    end

    ////////////////////////////////////////////////////////////
    // read response
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            rsp_valid_q <= 1'b0;
            rsp_q       <= '0;
        end else if (rd) begin
            rsp_valid_q <= 1'b1;                // visible next cycle
            rsp_q.rdata <= rd_data;
        end else if (rsp_ready) begin
            rsp_valid_q <= 1'b0;                // drained, hold data
        end
    end

    assign rsp_valid = rsp_valid_q;
    assign rsp       = rsp_q;

endmodule

// ==== hdl/ctc_timer_pkg.sv ====
package ctc_timer_pkg;

    ////////////////////////////////////////////////////////////
    // counter constants
    ////////////////////////////////////////////////////////////

    localparam int cnt_w       = 16;            // down-counter and reg word
    localparam int num_chan    = 2;             // channels in the block
    localparam int sync_stages = 2;             // event sync flops

    ////////////////////////////////////////////////////////////
    // register words
    ////////////////////////////////////////////////////////////

    // mode word, upper bits kept as written but unused
    typedef struct packed {
        logic [cnt_w-3:0] rsvd;                 // 15:2 reserved
        logic             repeat_en;            // bit 1, reload on expiry
        logic             counter_mode;         // bit 0, 1 = count events
    } ctc_mode_t;

    // status word as the CPU sees it
    typedef struct packed {
        logic             active;               // bit 15, counting
        logic [cnt_w-4:0] rsvd;                 // 14:2 read zero
        logic             done;                 // bit 1, counter expired
        logic             timeout;              // bit 0, timer expired
    } ctc_status_t;

    ////////////////////////////////////////////////////////////
    // regs <-> channel
    ////////////////////////////////////////////////////////////

    typedef struct packed {
        ctc_mode_t        mode;                 // current mode
        logic [cnt_w-1:0] init;                 // reload / start value
    } ctc_chan_cfg_t;

    // per-cycle report back to the status logic
    typedef struct packed {
        logic active;                           // level
        logic timeout_set;                      // 1-cycle pulse, timer expiry
        logic done_set;                         // 1-cycle pulse, counter expiry
    } ctc_chan_evt_t;

endpackage

// ==== hdl/ctc_top.sv ====
`timescale 1ns/1ns

module ctc_top (
    input  logic                               clock,
    input  logic                               arst_n,
    input  logic                               req_valid,
    output logic                               req_ready,
    input  ctc_bus_pkg::ctc_req_t              req,
    output logic                               rsp_valid,
    input  logic                               rsp_ready,
    output ctc_bus_pkg::ctc_rsp_t              rsp,
    input  logic [ctc_timer_pkg::num_chan-1:0] ev_in,   // raw event pins
    output logic [ctc_timer_pkg::num_chan-1:0] cout_n   // active low
);

    import ctc_timer_pkg::*;

    ctc_chan_cfg_t       cfg   [num_chan];      // regs -> channel
    logic [num_chan-1:0] load;                  // init write strobes
    logic [num_chan-1:0] stop;                  // mode write strobes
    logic [num_chan-1:0] tick;                  // sync -> channel
    logic [cnt_w-1:0]    count [num_chan];      // channel -> read mux
    ctc_chan_evt_t       evt   [num_chan];      // channel -> status

    ////////////////////////////////////////////////////////////
    // bus slave
    ////////////////////////////////////////////////////////////

    ctc_regs u_regs (
        .clock     (clock),
        .arst_n    (arst_n),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .req       (req),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .rsp       (rsp),
        .cfg       (cfg),
        .load      (load),
        .stop      (stop),
        .count     (count),
        .evt       (evt)
    );

    ////////////////////////////////////////////////////////////
    // event synchronizers
    ////////////////////////////////////////////////////////////

    ctc_event_sync u_sync0 (.clock(clock), .arst_n(arst_n), .ev_in(ev_in[0]), .tick(tick[0]));
    ctc_event_sync u_sync1 (.clock(clock), .arst_n(arst_n), .ev_in(ev_in[1]), .tick(tick[1]));

    ////////////////////////////////////////////////////////////
    // channels
    ////////////////////////////////////////////////////////////

    ctc_channel u_chan0 (
        .clock (clock), .arst_n (arst_n),
        .cfg   (cfg[0]), .load (load[0]), .stop (stop[0]), .tick (tick[0]),
        .count (count[0]), .evt (evt[0]), .cout_n (cout_n[0])
    );

    ctc_channel u_chan1 (
        .clock (clock), .arst_n (arst_n),
        .cfg   (cfg[1]), .load (load[1]), .stop (stop[1]), .tick (tick[1]),
        .count (count[1]), .evt (evt[1]), .cout_n (cout_n[1])
    );

endmodule

// ==== vlog.f ====
+incdir+dv
hdl/ctc_bus_pkg.sv
hdl/ctc_timer_pkg.sv
hdl/ctc_event_sync.sv
hdl/ctc_channel.sv
hdl/ctc_regs.sv
hdl/ctc_top.sv
dv/ctc_tb.sv
